//--- filelist.f
+incdir+bench
src/sftm_pkg.sv
src/patch_collector.sv
src/pre_transform.sv
src/sparse_channel_array.sv
src/post_transform.sv
src/group_serializer.sv
src/quality_modulator.sv
src/sftm_top.sv
bench/tb_sftm.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module tb_sftm -f filelist.f

run: compile
	@out="$$(./obj_dir/Vtb_sftm)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- bench/tb_sftm_model.svh
`ifndef TB_SFTM_MODEL_SVH
`define TB_SFTM_MODEL_SVH

// Clamp to the signed 16-bit sample range
function automatic int clamp_sample(longint v);
    if (v > 32767)
        return 32767;
    if (v < -32768)
        return -32768;
    return int'(v);
endfunction

// B-transpose down the columns, then B along the rows
function automatic void input_transform(input int d [16], output int c [16]);
    int t [16];
    for (int j = 0; j < 4; j++) begin
        t[j]    = d[j] - d[8+j];
        t[4+j]  = d[4+j] + d[8+j];
        t[8+j]  = d[8+j] - d[4+j];
        t[12+j] = d[4+j] - d[12+j];
    end
    for (int i = 0; i < 16; i += 4) begin
        c[i]   = clamp_sample(longint'(t[i] - t[i+2]));
        c[i+1] = clamp_sample(longint'(t[i+1] + t[i+2]));
        c[i+2] = clamp_sample(longint'(t[i+2] - t[i+1]));
        c[i+3] = clamp_sample(longint'(t[i+1] - t[i+3]));
    end
endfunction

// Sum of weight * coefficient over the entries of one channel that hit pos
function automatic int sparse_product(input int c [16], input int w [18], input int idx [18],
                                      input int ch, input int pos);
    longint acc;
    acc = 0;
    for (int e = 0; e < 6; e++) begin
        if (idx[ch*6+e] == pos)
            acc += longint'(w[ch*6+e]) * longint'(c[pos]);
    end
    return clamp_sample(acc);
endfunction

// A-transpose down the columns, then A along the rows, 4x4 to 2x2
function automatic void output_transform(input int m [16], output int r [4]);
    int t [8];
    for (int j = 0; j < 4; j++) begin
        t[j]   = m[j] + m[4+j] + m[8+j];
        t[4+j] = m[4+j] - m[8+j] - m[12+j];
    end
    for (int i = 0; i < 2; i++) begin
        r[2*i]   = clamp_sample(longint'(t[4*i] + t[4*i+1] + t[4*i+2]));
        r[2*i+1] = clamp_sample(longint'(t[4*i+1] - t[4*i+2] - t[4*i+3]));
    end
endfunction

function automatic int quality_shift(int v, int q);
    return v >>> q;
endfunction

`endif

//--- bench/tb_sftm.sv
`timescale 1ns/1ps
module tb_sftm import sftm_pkg::*; ();

    localparam int WEIGHT_ADDR_W = 12;
    // About 40 patches at 28 handshakes each, times 4 for stalls and margin
    localparam int CYCLE_LIMIT   = 6000;

    logic                     clk;
    logic                     rst_n;
    sample_t                  input_data;
    logic                     input_valid;
    logic                     input_ready;
    qmode_t                   quality_mode;
    sample_t                  weights [LIST_LEN];
    coef_idx_t                indexes [LIST_LEN];
    logic [WEIGHT_ADDR_W-1:0] weight_addr;
    sample_t                  group_data;
    logic                     group_data_valid;
    logic                     group_data_ready;
    logic                     group_done;

    int          w_list [LIST_LEN];
    int          i_list [LIST_LEN];
    int          expected [$];
    int          errors = 0;
    int          step_errors = 0;
    int          checked = 0;
    int          tiles_sent = 0;
    int          cycles = 0;
    int          out_pos = 0;
    bit          random_ready = 1'b0;
    bit          stalled = 1'b0;
    sample_t     last_data;
    logic [31:0] rng_state = 32'd29890;
    logic [31:0] ready_rng = 32'd29890;

    `include "tb_sftm_model.svh"

    sftm_top #(.WEIGHT_ADDR_W(WEIGHT_ADDR_W)) dut (
        .clk(clk), .rst_n(rst_n),
        .input_data(input_data), .input_valid(input_valid), .input_ready(input_ready),
        .quality_mode(quality_mode), .scu_weights(weights), .scu_indexes(indexes),
        .weight_addr(weight_addr), .group_data(group_data),
        .group_data_valid(group_data_valid), .group_data_ready(group_data_ready),
        .group_done(group_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ================================================
    // Run limit and output back-pressure
    // ================================================
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Ready low about a quarter of the time when stalls are on
    initial begin
        group_data_ready = 1'b1;
        forever begin
            @(negedge clk);
            ready_rng = xorshift32(ready_rng);
            group_data_ready = !random_ready || ready_rng[1:0] != 2'b00;
        end
    end

    // ================================================
    // Output scoreboard
    // ================================================
    always @(posedge clk) begin
        int want;
        if (rst_n) begin
            if (stalled) begin
                assert (group_data_valid && group_data == last_data)
                else begin
                    errors++;
                    $display("Output was dropped or changed during a stall at %0t", $time);
                end
            end
            if (group_data_valid && group_data_ready) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("Output sample at %0t arrived with nothing expected", $time);
                end else begin
                    want = expected.pop_front();
                    checked++;
                    assert (int'(group_data) == want)
                    else begin
                        errors++;
                        $display("[FAIL] %0t: sample %0d is %0d, expected %0d",
                                 $time, out_pos, group_data, want);
                    end
                    assert (group_done == (out_pos == OUT_PER_TILE - 1))
                    else begin
                        errors++;
                        $display("[FAIL] %0t: group_done is %0b at sample %0d",
                                 $time, group_done, out_pos);
                    end
                    out_pos = (out_pos + 1) % OUT_PER_TILE;
                end
            end
            stalled   = group_data_valid && !group_data_ready;
            last_data = group_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) group_done |-> group_data_valid)
    else begin
        errors++;
        $display("group_done was high without group_data_valid at %0t", $time);
    end

    // ================================================
    // Stimulus
    // ================================================
    function automatic void apply_list();
        for (int e = 0; e < LIST_LEN; e++) begin
            weights[e] = sample_t'(w_list[e]);
            indexes[e] = coef_idx_t'(i_list[e]);
        end
    endfunction

    function automatic void load_fixed_list();
        for (int e = 0; e < LIST_LEN; e++) begin
            i_list[e] = (5 * (e / NNZ) + 3 * (e % NNZ)) % TILE_N;
            w_list[e] = (e / NNZ == 1) ? -(e % NNZ + 1) : (e % NNZ + 1) * (e / NNZ + 1);
        end
        apply_list();
    endfunction

    // Distinct positions inside each channel, as in a real sparse list
    function automatic void load_random_list(input int wshift);
        bit          used [TILE_N];
        logic [31:0] r;
        for (int e = 0; e < LIST_LEN; e++) begin
            if (e % NNZ == 0) begin
                for (int i = 0; i < TILE_N; i++) begin
                    used[i] = 1'b0;
                end
            end
            r = next_random();
            while (used[r[3:0]])
                r = next_random();
            used[r[3:0]] = 1'b1;
            i_list[e] = int'(r[3:0]);
            w_list[e] = int'(sample_t'(r[31:16])) >>> wshift;
        end
        apply_list();
    endfunction

    // Twelve expected samples in channel order
    function automatic void predict_patch(input int p [TILE_N]);
        int c [TILE_N];
        int m [TILE_N];
        int r [4];
        input_transform(p, c);
        for (int ch = 0; ch < OUT_CH; ch++) begin
            for (int pos = 0; pos < TILE_N; pos++) begin
                m[pos] = sparse_product(c, w_list, i_list, ch, pos);
            end
            output_transform(m, r);
            for (int q = 0; q < 4; q++) begin
                expected.push_back(quality_shift(r[q], int'(quality_mode)));
            end
        end
    endfunction

    // Called and left on a falling edge, ready sampled at the rising edge
    task automatic send_patch(input int p [TILE_N], input bit gaps);
        logic [31:0] r;
        predict_patch(p);
        for (int i = 0; i < TILE_N; i++) begin
            r = next_random();
            if (gaps && r[1:0] == 2'b00) begin
                input_valid = 1'b0;
                @(negedge clk);
            end
            input_data  = sample_t'(p[i]);
            input_valid = 1'b1;
            @(posedge clk);
            while (!input_ready)
                @(posedge clk);
            @(negedge clk);
        end
        input_valid = 1'b0;
        tiles_sent++;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0)
            @(negedge clk);
        assert (weight_addr == WEIGHT_ADDR_W'(LIST_LEN * tiles_sent))
        else begin
            step_errors++;
            $display("[FAIL] %0t: weight_addr is %0d after %0d tiles",
                     $time, weight_addr, tiles_sent);
        end
    endtask

    // New random list every four patches, once the pipeline is empty
    task automatic run_random(input int n, input int pshift, input int wshift, input bit stall);
        int          p [TILE_N];
        logic [31:0] r;
        random_ready = stall;
        for (int t = 0; t < n; t++) begin
            if (t % 4 == 0) begin
                wait_drain();
                load_random_list(wshift);
            end
            for (int i = 0; i < TILE_N; i++) begin
                r    = next_random();
                p[i] = int'(sample_t'(r[15:0])) >>> pshift;
            end
            send_patch(p, stall);
        end
        wait_drain();
        random_ready = 1'b0;
    endtask

    initial begin
        int p [TILE_N];
        input_data   = '0;
        input_valid  = 1'b0;
        quality_mode = '0;
        for (int e = 0; e < LIST_LEN; e++) begin
            w_list[e] = 0;
            i_list[e] = 0;
        end
        apply_list();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!group_data_valid && !group_done && input_ready && weight_addr == '0)
        else begin
            step_errors++;
            $display("The outputs did not come out of reset in their idle state");
        end

        // Single ramp patch through the fixed list
        load_fixed_list();
        for (int i = 0; i < TILE_N; i++) begin
            p[i] = 100 * i - 700;
        end
        send_patch(p, 1'b0);
        wait_drain();

        run_random(12, 8, 11, 1'b0);
        run_random(12, 0, 6, 1'b1);

        // Full-scale patches and weights
        for (int k = 0; k < 4; k++) begin
            load_fixed_list();
            for (int e = 0; e < LIST_LEN; e++) begin
                w_list[e] = (e % 2 == k / 2) ? 32767 : -32768;
            end
            apply_list();
            for (int i = 0; i < TILE_N; i++) begin
                p[i] = (k % 2 == 0 || i % 2 == 0) ? 32767 : -32768;
            end
            send_patch(p, 1'b0);
            wait_drain();
        end

        for (int q = 0; q < 4; q++) begin
            quality_mode = qmode_t'(q);
            run_random(2, 2, 9, 1'b0);
        end

        $display("Summary: %0d samples checked, %0d output errors, %0d step errors",
                 checked, errors, step_errors);
        if (errors == 0 && step_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- src/sftm_top.sv
`timescale 1ns/1ps
module sftm_top import sftm_pkg::*; #(
    parameter int WEIGHT_ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sample_t                  input_data,
    input  logic                     input_valid,
    output logic                     input_ready,
    input  qmode_t                   quality_mode,
    input  sample_t                  scu_weights [LIST_LEN],
    input  coef_idx_t                scu_indexes [LIST_LEN],
    output logic [WEIGHT_ADDR_W-1:0] weight_addr,
    output sample_t                  group_data,
    output logic                     group_data_valid,
    input  logic                     group_data_ready,
    output logic                     group_done
);

    // Stage links
    sample_t patch [TILE_N];
    logic    patch_valid, patch_ready;
    sample_t coef [TILE_N];
    logic    coef_valid, coef_ready;
    sample_t prod0 [TILE_N];
    sample_t prod1 [TILE_N];
    sample_t prod2 [TILE_N];
    logic    prod_valid, prod_ready;
    sample_t res0 [4];
    sample_t res1 [4];
    sample_t res2 [4];
    logic    res_valid, res_ready;
    sample_t sample;
    logic    sample_last, sample_valid, sample_ready;

    patch_collector u_collect (
        .clk(clk), .rst_n(rst_n),
        .input_data(input_data), .input_valid(input_valid), .input_ready(input_ready),
        .patch(patch), .patch_valid(patch_valid), .patch_ready(patch_ready)
    );

    pre_transform u_pre (
        .clk(clk), .rst_n(rst_n),
        .patch(patch), .patch_valid(patch_valid), .patch_ready(patch_ready),
        .coef(coef), .coef_valid(coef_valid), .coef_ready(coef_ready)
    );

    sparse_channel_array #(
        .WEIGHT_ADDR_W(WEIGHT_ADDR_W)
    ) u_sca (
        .clk(clk), .rst_n(rst_n),
        .coef(coef), .coef_valid(coef_valid), .coef_ready(coef_ready),
        .scu_weights(scu_weights), .scu_indexes(scu_indexes),
        .prod0(prod0), .prod1(prod1), .prod2(prod2),
        .prod_valid(prod_valid), .prod_ready(prod_ready),
        .weight_addr(weight_addr)
    );

    post_transform u_post (
        .clk(clk), .rst_n(rst_n),
        .prod0(prod0), .prod1(prod1), .prod2(prod2),
        .prod_valid(prod_valid), .prod_ready(prod_ready),
        .res0(res0), .res1(res1), .res2(res2),
        .res_valid(res_valid), .res_ready(res_ready)
    );

    group_serializer u_ser (
        .clk(clk), .rst_n(rst_n),
        .res0(res0), .res1(res1), .res2(res2),
        .res_valid(res_valid), .res_ready(res_ready),
        .sample(sample), .sample_last(sample_last),
        .sample_valid(sample_valid), .sample_ready(sample_ready)
    );

    quality_modulator u_qmu (
        .clk(clk), .rst_n(rst_n),
        .sample(sample), .sample_last(sample_last),
        .sample_valid(sample_valid), .sample_ready(sample_ready),
        .quality_mode(quality_mode),
        .group_data(group_data), .group_done(group_done),
        .group_data_valid(group_data_valid), .group_data_ready(group_data_ready)
    );

endmodule

//--- src/quality_modulator.sv
`timescale 1ns/1ps
module quality_modulator import sftm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    input  logic    sample_last,
    input  logic    sample_valid,
    output logic    sample_ready,
    input  qmode_t  quality_mode,
    output sample_t group_data,
    output logic    group_done,
    output logic    group_data_valid,
    input  logic    group_data_ready
);

    logic load;

    assign sample_ready = !group_data_valid || group_data_ready;
    assign load         = sample_valid && sample_ready;

    // group_done only ever high alongside group_data_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_data_valid <= 1'b0;
            group_done       <= 1'b0;
        end else if (load) begin
            group_data_valid <= 1'b1;
            group_done       <= sample_last;
        end else if (group_data_ready) begin
            group_data_valid <= 1'b0;
            group_done       <= 1'b0;
        end
    end

    // Arithmetic shift keeps the sign
    always_ff @(posedge clk) begin
        if (load)
            group_data <= sat_to_sample(acc_t'(sample) >>> quality_mode);
    end

endmodule

//--- src/group_serializer.sv
`timescale 1ns/1ps
module group_serializer import sftm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t res0 [4],
    input  sample_t res1 [4],
    input  sample_t res2 [4],
    input  logic    res_valid,
    output logic    res_ready,
    output sample_t sample,
    output logic    sample_last,
    output logic    sample_valid,
    input  logic    sample_ready
);

    sample_t    hold [OUT_CH][4];
    logic [3:0] out_cnt;
    logic       held;
    logic       load;
    logic       out_fire;

    // Next result may enter as the 12th sample leaves
    assign sample_last  = out_cnt == 4'(OUT_PER_TILE-1);
    assign sample_valid = held;
    assign out_fire     = held && sample_ready;
    assign res_ready    = !held || (sample_ready && sample_last);
    assign load         = res_valid && res_ready;

    // Channel in the upper count bits, 2x2 position in the lower two
    assign sample = hold[out_cnt[3:2]][out_cnt[1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held    <= 1'b0;
            out_cnt <= '0;
        end else begin
            if (load) begin
                held    <= 1'b1;
                out_cnt <= '0;
            end else if (out_fire) begin
                if (sample_last) begin
                    held    <= 1'b0;
                    out_cnt <= '0;
                end else begin
                    out_cnt <= out_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold[0] <= res0;
            hold[1] <= res1;
            hold[2] <= res2;
        end
    end

endmodule

//--- src/post_transform.sv
`timescale 1ns/1ps
module post_transform import sftm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t prod0 [TILE_N],
    input  sample_t prod1 [TILE_N],
    input  sample_t prod2 [TILE_N],
    input  logic    prod_valid,
    output logic    prod_ready,
    output sample_t res0 [4],
    output sample_t res1 [4],
    output sample_t res2 [4],
    output logic    res_valid,
    input  logic    res_ready
);

    // Rows of A-transpose for the 4x4 to 2x2 reduction
    localparam int AT [2][4] = '{
        '{1, 1,  1,  0},
        '{0, 1, -1, -1}
    };

    sample_t m [OUT_CH][TILE_N];
    acc_t    t [OUT_CH][2][4];
    acc_t    r [OUT_CH][2][2];
    sample_t res_q [OUT_CH][4];
    logic    load;

    assign prod_ready = !res_valid || res_ready;
    assign load       = prod_valid && prod_ready;

    assign m[0] = prod0;
    assign m[1] = prod1;
    assign m[2] = prod2;

    // All three channels reduced in parallel
    always_comb begin
        for (int c = 0; c < OUT_CH; c++) begin
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < 4; j++) begin
                    t[c][i][j] = '0;
                    for (int k = 0; k < 4; k++) begin
                        t[c][i][j] += acc_t'(AT[i][k]) * acc_t'(m[c][k*4+j]);
                    end
                end
                for (int j = 0; j < 2; j++) begin
                    r[c][i][j] = '0;
                    for (int k = 0; k < 4; k++) begin
                        r[c][i][j] += t[c][i][k] * acc_t'(AT[j][k]);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else if (load)
            res_valid <= 1'b1;
        else if (res_ready)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int c = 0; c < OUT_CH; c++) begin
                for (int q = 0; q < 4; q++) begin
                    res_q[c][q] <= sat_to_sample(r[c][q/2][q%2]);
                end
            end
        end
    end

    assign res0 = res_q[0];
    assign res1 = res_q[1];
    assign res2 = res_q[2];

endmodule

//--- src/sparse_channel_array.sv
`timescale 1ns/1ps
module sparse_channel_array import sftm_pkg::*; #(
    parameter int WEIGHT_ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sample_t                  coef [TILE_N],
    input  logic                     coef_valid,
    output logic                     coef_ready,
    input  sample_t                  scu_weights [LIST_LEN],
    input  coef_idx_t                scu_indexes [LIST_LEN],
    output sample_t                  prod0 [TILE_N],
    output sample_t                  prod1 [TILE_N],
    output sample_t                  prod2 [TILE_N],
    output logic                     prod_valid,
    input  logic                     prod_ready,
    output logic [WEIGHT_ADDR_W-1:0] weight_addr
);

    acc_t    sum [OUT_CH][TILE_N];
    sample_t prod_q [OUT_CH][TILE_N];
    logic    load;

    assign coef_ready = !prod_valid || prod_ready;
    assign load       = coef_valid && coef_ready;

    // ================================================
    // Sparse list multiply
    // ================================================
    // Channel k owns list entries k*NNZ .. k*NNZ+NNZ-1
    always_comb begin
        for (int k = 0; k < OUT_CH; k++) begin
            for (int p = 0; p < TILE_N; p++) begin
                sum[k][p] = '0;
                for (int e = 0; e < NNZ; e++) begin
                    if (scu_indexes[k*NNZ+e] == coef_idx_t'(p))
                        sum[k][p] += acc_t'(scu_weights[k*NNZ+e]) * acc_t'(coef[p]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int k = 0; k < OUT_CH; k++) begin
                for (int p = 0; p < TILE_N; p++) begin
                    prod_q[k][p] <= sat_to_sample(sum[k][p]);
                end
            end
        end
    end

    assign prod0 = prod_q[0];
    assign prod1 = prod_q[1];
    assign prod2 = prod_q[2];

    // ================================================
    // Handshake and list base pointer
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid  <= 1'b0;
            weight_addr <= '0;
        end else begin
            if (load)
                prod_valid <= 1'b1;
            else if (prod_ready)
                prod_valid <= 1'b0;
            // One list per tile, wraps at the address width
            if (load)
                weight_addr <= weight_addr + WEIGHT_ADDR_W'(LIST_LEN);
        end
    end

endmodule

//--- src/pre_transform.sv
`timescale 1ns/1ps
module pre_transform import sftm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t patch [TILE_N],
    input  logic    patch_valid,
    output logic    patch_ready,
    output sample_t coef [TILE_N],
    output logic    coef_valid,
    input  logic    coef_ready
);

    // Winograd F(2x2,3x3) input transform, rows of B-transpose
    localparam int BT [4][4] = '{
        '{1,  0, -1,  0},
        '{0,  1,  1,  0},
        '{0, -1,  1,  0},
        '{0,  1,  0, -1}
    };

    acc_t t [4][4];
    acc_t s [4][4];
    logic load;

    assign patch_ready = !coef_valid || coef_ready;
    assign load        = patch_valid && patch_ready;

    // Left multiply by B-transpose
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                t[i][j] = '0;
                for (int k = 0; k < 4; k++) begin
                    t[i][j] += acc_t'(BT[i][k]) * acc_t'(patch[k*4+j]);
                end
            end
        end
    end

    // Right multiply by B
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                s[i][j] = '0;
                for (int k = 0; k < 4; k++) begin
                    s[i][j] += t[i][k] * acc_t'(BT[j][k]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            coef_valid <= 1'b0;
        else if (load)
            coef_valid <= 1'b1;
        else if (coef_ready)
            coef_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int p = 0; p < TILE_N; p++) begin
                coef[p] <= sat_to_sample(s[p/4][p%4]);
            end
        end
    end

endmodule

//--- src/patch_collector.sv
`timescale 1ns/1ps
module patch_collector import sftm_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t input_data,
    input  logic    input_valid,
    output logic    input_ready,
    output sample_t patch [TILE_N],
    output logic    patch_valid,
    input  logic    patch_ready
);

    logic [3:0] fill_cnt;
    sample_t    fill [TILE_N-1];
    logic       in_fire;
    logic       last_in;

    // Only the closing sample has to wait for the held patch to drain
    assign input_ready = !(patch_valid && !patch_ready && fill_cnt == 4'(TILE_N-1));
    assign in_fire     = input_valid && input_ready;
    assign last_in     = in_fire && fill_cnt == 4'(TILE_N-1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt    <= '0;
            patch_valid <= 1'b0;
        end else begin
            // Counter wraps to zero after the 16th sample
            if (in_fire)
                fill_cnt <= fill_cnt + 4'd1;
            if (last_in)
                patch_valid <= 1'b1;
            else if (patch_ready)
                patch_valid <= 1'b0;
        end
    end

    // Row-major fill, last sample goes straight into the patch
    always_ff @(posedge clk) begin
        if (in_fire && !last_in)
            fill[fill_cnt] <= input_data;
        if (last_in) begin
            for (int i = 0; i < TILE_N-1; i++) begin
                patch[i] <= fill[i];
            end
            patch[TILE_N-1] <= input_data;
        end
    end

endmodule

//--- src/sftm_pkg.sv
package sftm_pkg;

    // ================================================
    // Datapath widths and word types
    // ================================================
    localparam int DATA_W = 16;
    localparam int ACC_W  = 32;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [3:0]               coef_idx_t;
    typedef logic [1:0]               qmode_t;

    // ================================================
    // Tile and sparse list geometry
    // ================================================
    localparam int TILE_N       = 16;
    localparam int OUT_CH       = 3;
    localparam int NNZ          = 6;
    localparam int LIST_LEN     = OUT_CH * NNZ;
    localparam int OUT_PER_TILE = OUT_CH * 4;

    // Sample range limits
    localparam sample_t SAMPLE_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // Clamp a wide sum into the sample range
    function automatic sample_t sat_to_sample(acc_t v);
        if (v > acc_t'(SAMPLE_MAX))
            return SAMPLE_MAX;
        else if (v < acc_t'(SAMPLE_MIN))
            return SAMPLE_MIN;
        else
            return v[DATA_W-1:0];
    endfunction

endpackage
